// File: rtl/pu_defs.svh
`ifndef PU_DEFS_SVH
`define PU_DEFS_SVH

// ============================================================
// word and field widths
// ============================================================
`define PU_INST_W       32
`define PU_IMM_W        16
`define PU_STRIDE_W     32
`define PU_OPCODE_W     4
`define PU_SPEC_W       7
`define PU_LOOP_ID_W    5

// alu side
`define PU_RF_ADDR_W    4  // msb set selects a stream
`define PU_FN_W         3

// instruction memory, 256 words
`define PU_IMEM_ADDR_W  8

`endif

// File: rtl/pu_pkg.sv
`include "pu_defs.svh"

package pu_pkg;

  typedef enum logic [`PU_OPCODE_W-1:0] {
    SETUP        = 4'd0,
    LDMEM        = 4'd1,
    STMEM        = 4'd2,
    RDBUF        = 4'd3,
    WRBUF        = 4'd4,
    GENADDR_HI   = 4'd5,
    GENADDR_LO   = 4'd6,
    LOOP         = 4'd7,
    BLOCK_REPEAT = 4'd8,
    BASE_ADDR    = 4'd9,
    PU_BLOCK     = 4'd10,
    COMPUTE_R    = 4'd11,
    COMPUTE_I    = 4'd12
  } pu_opcode_e;

  typedef enum logic [2:0] {
    IDLE,
    DECODE,
    COMPUTE_WAIT,
    COMPUTE,
    DONE
  } pu_state_e;

  // low bits of a stream register address
  typedef enum logic [`PU_RF_ADDR_W-2:0] {
    LD_OBUF = 3'd0,
    LD0_DDR = 3'd1,
    LD1_DDR = 3'd2
  } pu_src_e;

  typedef struct packed {
    pu_opcode_e                opcode;
    logic [`PU_SPEC_W-1:0]     spec;
    logic [`PU_LOOP_ID_W-1:0]  loop_id;
    logic [`PU_IMM_W-1:0]      imm;
  } pu_ctrl_fields_t;

  typedef struct packed {
    pu_opcode_e                opcode;
    logic                      in1_src;   // 1 selects the immediate
    logic [`PU_FN_W-1:0]       fn;
    logic [`PU_IMM_W-1:0]      imm;       // low bits double as in1 address
    logic [`PU_RF_ADDR_W-1:0]  in0_addr;
    logic [`PU_RF_ADDR_W-1:0]  out_addr;
  } pu_alu_fields_t;

  typedef union packed {
    pu_ctrl_fields_t ctrl;
    pu_alu_fields_t  alu;
  } pu_inst_u;

endpackage

// File: rtl/pu_imem_if.sv
`timescale 1ns/100ps
`include "pu_defs.svh"

interface pu_imem_if;
  import pu_pkg::*;

  logic                        wr_en;
  pu_inst_u                    wr_data;
  logic                        rd_en;
  logic [`PU_IMEM_ADDR_W-1:0]  rd_addr;
  logic                        clear;      // rewinds the write pointer
  pu_inst_u                    rd_data;    // valid one cycle after rd_en
  logic [`PU_IMEM_ADDR_W-1:0]  last_addr;  // newest stored word

  modport writer (output wr_en, output wr_data);

  modport reader (output rd_en, output rd_addr, output clear,
                  input rd_data, input last_addr);

  modport mem (input wr_en, input wr_data, input rd_en, input rd_addr,
               input clear, output rd_data, output last_addr);

endinterface

// File: rtl/pu_inst_mem.sv
`timescale 1ns/100ps
`include "pu_defs.svh"

module pu_inst_mem (
  input  logic       clk,
  input  logic       reset,
  pu_imem_if.mem     port
);
  import pu_pkg::*;

  localparam int DEPTH = 1 << `PU_IMEM_ADDR_W;

  pu_inst_u                  mem [DEPTH];
  logic [`PU_IMEM_ADDR_W:0]  wr_ptr;  // extra bit marks full

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr         <= '0;
      port.last_addr <= '0;
    end else if (port.clear) begin
      wr_ptr <= '0;
    end else if (port.wr_en) begin
      wr_ptr         <= wr_ptr + 1'b1;
      port.last_addr <= wr_ptr[`PU_IMEM_ADDR_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (port.wr_en) begin
      mem[wr_ptr[`PU_IMEM_ADDR_W-1:0]] <= port.wr_data;
    end
  end

  // rd_data holds between reads
  always_ff @(posedge clk) begin
    if (port.rd_en) begin
      port.rd_data <= mem[port.rd_addr];
    end
  end

  // decoder must not overfill the block
  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    port.wr_en |-> !wr_ptr[`PU_IMEM_ADDR_W]);

endmodule

// File: rtl/pu_inst_decode.sv
`timescale 1ns/100ps
`include "pu_defs.svh"

module pu_inst_decode (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     inst_req,
  input  pu_pkg::pu_inst_u         inst_data,
  input  logic                     decode_en,
  output logic                     inst_ack,
  output logic                     cfg_loop_iter_v,
  output logic [`PU_IMM_W-1:0]     cfg_loop_iter,
  output logic [2:0]               cfg_loop_iter_type,
  output logic                     cfg_loop_stride_v,
  output logic [`PU_STRIDE_W-1:0]  cfg_loop_stride,
  output logic [3:0]               cfg_loop_stride_type,
  output logic                     cfg_mem_req_v,
  output logic [1:0]               cfg_mem_req_type,
  output logic [2:0]               upsample_num,
  output logic                     block_end,
  output logic [`PU_IMM_W-1:0]     block_repeat,
  pu_imem_if.writer                imem
);
  import pu_pkg::*;

  pu_ctrl_fields_t                     word;
  logic                                accept;
  logic [`PU_STRIDE_W-`PU_IMM_W-1:0]   stride_hi;

  assign word   = inst_data.ctrl;
  assign accept = decode_en && inst_req && !inst_ack;  // one word per req

  // ============================================================
  // four-phase intake
  // ============================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      inst_ack <= 1'b0;
    end else if (accept) begin
      inst_ack <= 1'b1;
    end else if (!inst_req) begin
      inst_ack <= 1'b0;  // follows req down
    end
  end

  // pulses line up with the rising ack
  always_ff @(posedge clk) begin
    if (reset) begin
      cfg_loop_iter_v   <= 1'b0;
      cfg_loop_stride_v <= 1'b0;
      cfg_mem_req_v     <= 1'b0;
      block_end         <= 1'b0;
      imem.wr_en        <= 1'b0;
    end else begin
      cfg_loop_iter_v   <= accept && (word.opcode == LOOP);
      cfg_loop_stride_v <= accept && (word.opcode == GENADDR_LO);
      cfg_mem_req_v     <= accept && (word.opcode == LDMEM);
      block_end         <= accept && (word.opcode == BLOCK_REPEAT);
      imem.wr_en        <= accept && (word.opcode inside {COMPUTE_R, COMPUTE_I});
    end
  end

  // high half waits for its GENADDR_LO
  always_ff @(posedge clk) begin
    if (reset) begin
      stride_hi <= '0;
    end else if (!decode_en) begin
      stride_hi <= '0;  // also covers done
    end else if (accept && word.opcode == GENADDR_LO) begin
      stride_hi <= '0;
    end else if (accept && word.opcode == GENADDR_HI) begin
      stride_hi <= word.imm;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cfg_loop_iter        <= word.imm;
      cfg_loop_iter_type   <= word.spec[2:0];
      cfg_loop_stride      <= {stride_hi, word.imm};
      cfg_loop_stride_type <= word.spec[3:0];
      cfg_mem_req_type     <= word.spec[4:3];
      upsample_num         <= word.spec[2:0];
      block_repeat         <= word.imm;
      imem.wr_data         <= inst_data;  // whole word, alu view read later
    end
  end

  // host keeps req up until it sees ack
  a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    $rose(inst_ack) |-> inst_req);

endmodule

// File: rtl/pu_replay_seq.sv
`timescale 1ns/100ps
`include "pu_defs.svh"

module pu_replay_seq (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  pu_block_start,
  input  logic                  pu_compute_start,
  input  logic                  block_end,
  input  logic [`PU_IMM_W-1:0]  block_repeat,
  input  logic                  stall,
  output logic                  decode_en,
  output logic                  pu_compute_ready,
  output logic                  done,
  output logic                  issue_valid,
  output pu_pkg::pu_inst_u      issue_inst,
  pu_imem_if.reader             imem
);
  import pu_pkg::*;

  pu_state_e                   state;
  pu_state_e                   state_next;
  logic [`PU_IMM_W-1:0]        repeat_cnt;  // passes left after this one
  logic [`PU_IMEM_ADDR_W-1:0]  rd_addr;
  logic [`PU_IMEM_ADDR_W-1:0]  issue_addr;
  logic                        fetch_en;
  logic                        at_block_end;
  logic                        last_word;
  logic                        finish;

  assign at_block_end = issue_valid && (issue_addr == imem.last_addr);
  assign last_word    = at_block_end && (repeat_cnt == '0);
  assign finish       = last_word && !stall;

  // ============================================================
  // controller FSM
  // ============================================================
  always_comb begin
    state_next = state;
    case (state)
      IDLE:         if (pu_block_start) state_next = DECODE;
      DECODE:       if (block_end) state_next = COMPUTE_WAIT;
      COMPUTE_WAIT: if (pu_compute_start) state_next = COMPUTE;
      COMPUTE:      if (finish) state_next = DONE;
      default:      state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      repeat_cnt <= '0;
    end else if (state == DECODE && block_end) begin
      repeat_cnt <= block_repeat;
    end else if (at_block_end && !stall && repeat_cnt != '0) begin
      repeat_cnt <= repeat_cnt - 1'b1;
    end
  end

  // ============================================================
  // replay addressing
  // ============================================================
  // reads start one cycle into COMPUTE
  always_ff @(posedge clk) begin
    if (reset) begin
      fetch_en    <= 1'b0;
      issue_valid <= 1'b0;
    end else begin
      fetch_en <= (state == COMPUTE) && !finish;
      if (!stall) begin
        issue_valid <= imem.rd_en;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_addr    <= '0;
      issue_addr <= '0;
    end else if (state == DONE) begin
      rd_addr <= '0;
    end else if (imem.rd_en) begin
      rd_addr    <= (rd_addr == imem.last_addr) ? '0 : rd_addr + 1'b1;
      issue_addr <= rd_addr;
    end
  end

  assign imem.rd_en   = fetch_en && !stall && !last_word;
  assign imem.rd_addr = rd_addr;
  assign imem.clear   = (state == DONE);
  assign issue_inst   = imem.rd_data;  // held by memory while stalled

  assign decode_en        = (state == DECODE);
  assign pu_compute_ready = (state == COMPUTE_WAIT);
  assign done             = (state == DONE);

  a_issue_in_compute: assert property (@(posedge clk) disable iff (reset)
    issue_valid |-> state == COMPUTE);

endmodule

// File: rtl/pu_stream_issue.sv
`timescale 1ns/100ps
`include "pu_defs.svh"

module pu_stream_issue (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      issue_valid,
  input  pu_pkg::pu_inst_u          issue_inst,
  input  logic                      obuf_ld_ready,
  input  logic                      ddr_ld0_ready,
  input  logic                      ddr_ld1_ready,
  input  logic                      ddr_st_write_ready,
  output logic                      stall,
  output logic                      alu_fn_valid,
  output logic [`PU_FN_W-1:0]       alu_fn,
  output logic [`PU_RF_ADDR_W-1:0]  alu_in0_addr,
  output logic                      alu_in1_src,
  output logic [`PU_RF_ADDR_W-1:0]  alu_in1_addr,
  output logic [`PU_RF_ADDR_W-1:0]  alu_out_addr,
  output logic [`PU_IMM_W-1:0]      alu_imm,
  output logic                      obuf_ld_req,
  output logic                      ddr_ld0_req,
  output logic                      ddr_ld1_req,
  output logic                      ddr_st_write_req
);
  import pu_pkg::*;

  pu_alu_fields_t  alu;
  logic            need_obuf;
  logic            need_ld0;
  logic            need_ld1;
  logic            need_st;
  logic [1:0]      st_dly;  // store request delay line

  // either operand may read the stream, in1 only when not immediate
  function automatic logic needs_src(input pu_alu_fields_t w, input pu_src_e src);
    logic [`PU_RF_ADDR_W-1:0] in1;
    in1 = w.imm[`PU_RF_ADDR_W-1:0];
    return (w.in0_addr[`PU_RF_ADDR_W-1] && w.in0_addr[`PU_RF_ADDR_W-2:0] == src) ||
           (!w.in1_src && in1[`PU_RF_ADDR_W-1] && in1[`PU_RF_ADDR_W-2:0] == src);
  endfunction

  assign alu          = issue_inst.alu;
  assign alu_fn       = alu.fn;
  assign alu_in0_addr = alu.in0_addr;
  assign alu_in1_src  = alu.in1_src;
  assign alu_in1_addr = alu.imm[`PU_RF_ADDR_W-1:0];
  assign alu_out_addr = alu.out_addr;
  assign alu_imm      = alu.imm;

  assign need_obuf = issue_valid && needs_src(alu, LD_OBUF);
  assign need_ld0  = issue_valid && needs_src(alu, LD0_DDR);
  assign need_ld1  = issue_valid && needs_src(alu, LD1_DDR);
  assign need_st   = issue_valid && alu.out_addr[`PU_RF_ADDR_W-1];

  assign stall = (need_obuf && !obuf_ld_ready) || (need_ld0 && !ddr_ld0_ready) ||
                 (need_ld1 && !ddr_ld1_ready) || (need_st && !ddr_st_write_ready);

  assign alu_fn_valid = issue_valid && !stall;
  assign obuf_ld_req  = need_obuf && !stall;
  assign ddr_ld0_req  = need_ld0 && !stall;
  assign ddr_ld1_req  = need_ld1 && !stall;

  // result is ready two cycles after issue
  always_ff @(posedge clk) begin
    if (reset) begin
      st_dly <= '0;
    end else begin
      st_dly <= {st_dly[0], need_st && !stall};
    end
  end

  assign ddr_st_write_req = st_dly[1];

endmodule

// File: rtl/pu_ctrl_top.sv
`timescale 1ns/100ps
`include "pu_defs.svh"

module pu_ctrl_top (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      pu_block_start,
  input  logic                      pu_compute_start,
  output logic                      pu_compute_ready,
  output logic                      done,
  input  logic                      inst_req,
  input  logic [`PU_INST_W-1:0]     inst_data,
  output logic                      inst_ack,
  output logic                      cfg_loop_iter_v,
  output logic [`PU_IMM_W-1:0]      cfg_loop_iter,
  output logic [2:0]                cfg_loop_iter_type,
  output logic                      cfg_loop_stride_v,
  output logic [`PU_STRIDE_W-1:0]   cfg_loop_stride,
  output logic [3:0]                cfg_loop_stride_type,
  output logic                      cfg_mem_req_v,
  output logic [1:0]                cfg_mem_req_type,
  output logic [2:0]                upsample_num,
  output logic                      alu_fn_valid,
  output logic [`PU_FN_W-1:0]       alu_fn,
  output logic [`PU_RF_ADDR_W-1:0]  alu_in0_addr,
  output logic                      alu_in1_src,
  output logic [`PU_RF_ADDR_W-1:0]  alu_in1_addr,
  output logic [`PU_RF_ADDR_W-1:0]  alu_out_addr,
  output logic [`PU_IMM_W-1:0]      alu_imm,
  output logic                      obuf_ld_req,
  input  logic                      obuf_ld_ready,
  output logic                      ddr_ld0_req,
  input  logic                      ddr_ld0_ready,
  output logic                      ddr_ld1_req,
  input  logic                      ddr_ld1_ready,
  output logic                      ddr_st_write_req,
  input  logic                      ddr_st_write_ready
);
  import pu_pkg::*;

  logic                  decode_en;
  logic                  block_end;
  logic [`PU_IMM_W-1:0]  block_repeat;
  logic                  stall;
  logic                  issue_valid;
  pu_inst_u              issue_inst;

  pu_imem_if i_imem_if ();

  pu_inst_mem i_inst_mem (
    .clk   (clk),
    .reset (reset),
    .port  (i_imem_if.mem)
  );

  pu_inst_decode i_inst_decode (
    .clk                  (clk),
    .reset                (reset),
    .inst_req             (inst_req),
    .inst_data            (inst_data),
    .decode_en            (decode_en),
    .inst_ack             (inst_ack),
    .cfg_loop_iter_v      (cfg_loop_iter_v),
    .cfg_loop_iter        (cfg_loop_iter),
    .cfg_loop_iter_type   (cfg_loop_iter_type),
    .cfg_loop_stride_v    (cfg_loop_stride_v),
    .cfg_loop_stride      (cfg_loop_stride),
    .cfg_loop_stride_type (cfg_loop_stride_type),
    .cfg_mem_req_v        (cfg_mem_req_v),
    .cfg_mem_req_type     (cfg_mem_req_type),
    .upsample_num         (upsample_num),
    .block_end            (block_end),
    .block_repeat         (block_repeat),
    .imem                 (i_imem_if.writer)
  );

  pu_replay_seq i_replay_seq (
    .clk              (clk),
    .reset            (reset),
    .pu_block_start   (pu_block_start),
    .pu_compute_start (pu_compute_start),
    .block_end        (block_end),
    .block_repeat     (block_repeat),
    .stall            (stall),
    .decode_en        (decode_en),
    .pu_compute_ready (pu_compute_ready),
    .done             (done),
    .issue_valid      (issue_valid),
    .issue_inst       (issue_inst),
    .imem             (i_imem_if.reader)
  );

  pu_stream_issue i_stream_issue (
    .clk                (clk),
    .reset              (reset),
    .issue_valid        (issue_valid),
    .issue_inst         (issue_inst),
    .obuf_ld_ready      (obuf_ld_ready),
    .ddr_ld0_ready      (ddr_ld0_ready),
    .ddr_ld1_ready      (ddr_ld1_ready),
    .ddr_st_write_ready (ddr_st_write_ready),
    .stall              (stall),
    .alu_fn_valid       (alu_fn_valid),
    .alu_fn             (alu_fn),
    .alu_in0_addr       (alu_in0_addr),
    .alu_in1_src        (alu_in1_src),
    .alu_in1_addr       (alu_in1_addr),
    .alu_out_addr       (alu_out_addr),
    .alu_imm            (alu_imm),
    .obuf_ld_req        (obuf_ld_req),
    .ddr_ld0_req        (ddr_ld0_req),
    .ddr_ld1_req        (ddr_ld1_req),
    .ddr_st_write_req   (ddr_st_write_req)
  );

endmodule

// File: tb/pu_ctrl_tb.sv
`timescale 1ns/100ps
`include "pu_defs.svh"

module pu_ctrl_tb;
  import pu_pkg::*;

  localparam int TIMEOUT = 200;  // cycles per handshake wait
  localparam int N_WORDS = 6;

  logic                      clk = 1'b0;
  logic                      reset;
  logic                      pu_block_start;
  logic                      pu_compute_start;
  logic                      pu_compute_ready;
  logic                      done;
  logic                      inst_req;
  logic [`PU_INST_W-1:0]     inst_data;
  logic                      inst_ack;
  logic                      cfg_loop_iter_v;
  logic [`PU_IMM_W-1:0]      cfg_loop_iter;
  logic [2:0]                cfg_loop_iter_type;
  logic                      cfg_loop_stride_v;
  logic [`PU_STRIDE_W-1:0]   cfg_loop_stride;
  logic [3:0]                cfg_loop_stride_type;
  logic                      cfg_mem_req_v;
  logic [1:0]                cfg_mem_req_type;
  logic [2:0]                upsample_num;
  logic                      alu_fn_valid;
  logic [`PU_FN_W-1:0]       alu_fn;
  logic [`PU_RF_ADDR_W-1:0]  alu_in0_addr;
  logic                      alu_in1_src;
  logic [`PU_RF_ADDR_W-1:0]  alu_in1_addr;
  logic [`PU_RF_ADDR_W-1:0]  alu_out_addr;
  logic [`PU_IMM_W-1:0]      alu_imm;
  logic                      obuf_ld_req;
  logic                      obuf_ld_ready;
  logic                      ddr_ld0_req;
  logic                      ddr_ld0_ready;
  logic                      ddr_ld1_req;
  logic                      ddr_ld1_ready;
  logic                      ddr_st_write_req;
  logic                      ddr_st_write_ready;

  pu_alu_fields_t  model[$];        // words of the current block
  logic [2:0]      ack_valids;      // {iter, stride, mem} at rising ack
  int              iter_pulses = 0;
  int              stride_pulses = 0;
  int              mem_pulses = 0;

  pu_ctrl_top i_dut (.*);

  always #2 clk = ~clk;

  always @(negedge clk) begin
    if (cfg_loop_iter_v) iter_pulses++;
    if (cfg_loop_stride_v) stride_pulses++;
    if (cfg_mem_req_v) mem_pulses++;
  end

  // ============================================================
  // compare tasks
  // ============================================================
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_cfg_iter(input string name, input logic [`PU_IMM_W-1:0] act,
                                input logic [`PU_IMM_W-1:0] exp);
    if (act !== exp) begin
      report_failure($sformatf("ERROR @%0t: %s = %h, expected %h", $time, name, act, exp));
    end
  endtask

  task automatic check_cfg_stride(input string name, input logic [`PU_STRIDE_W-1:0] act,
                                  input logic [`PU_STRIDE_W-1:0] exp);
    if (act !== exp) begin
      report_failure($sformatf("ERROR @%0t: %s = %h, expected %h", $time, name, act, exp));
    end
  endtask

  task automatic check_type(input string name, input logic [3:0] act, input logic [3:0] exp);
    if (act !== exp) begin
      report_failure($sformatf("ERROR @%0t: %s = %h, expected %h", $time, name, act, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      report_failure($sformatf("ERROR @%0t: %s = %b, expected %b", $time, name, act, exp));
    end
  endtask

  task automatic check_count(input string name, input int act, input int exp);
    if (act != exp) begin
      report_failure($sformatf("ERROR @%0t: %s = %0d, expected %0d", $time, name, act, exp));
    end
  endtask

  task automatic check_opcode(input string name, input pu_opcode_e act, input pu_opcode_e exp);
    if (act !== exp) begin
      report_failure($sformatf("ERROR @%0t: %s = %0d, expected %0d", $time, name, act, exp));
    end
  endtask

  task automatic check_alu(input string name, input pu_alu_fields_t act,
                           input pu_alu_fields_t exp);
    if (act !== exp) begin
      report_failure($sformatf("ERROR @%0t: %s = %h, expected %h", $time, name, act, exp));
    end
  endtask

  // ============================================================
  // stimulus and reference model
  // ============================================================
  function automatic pu_inst_u ctrl_word(input pu_opcode_e op, input logic [`PU_SPEC_W-1:0] spec,
                                         input logic [`PU_IMM_W-1:0] imm);
    pu_inst_u w;
    w.ctrl.opcode  = op;
    w.ctrl.spec    = spec;
    w.ctrl.loop_id = `PU_LOOP_ID_W'($urandom);  // ignored by decode
    w.ctrl.imm     = imm;
    return w;
  endfunction

  function automatic pu_alu_fields_t rand_compute();
    pu_alu_fields_t a;
    a.opcode   = ($urandom % 2) ? COMPUTE_R : COMPUTE_I;
    a.in1_src  = 1'($urandom);
    a.fn       = `PU_FN_W'($urandom);
    a.imm      = `PU_IMM_W'($urandom);
    a.in0_addr = ($urandom % 2) ? 4'(8 + $urandom % 3) : 4'($urandom);  // favour streams
    a.out_addr = 4'($urandom);
    return a;
  endfunction

  // stream operand is msb set plus source code
  function automatic logic uses_src(input pu_alu_fields_t a, input pu_src_e src);
    logic [3:0] in1;
    in1 = a.imm[3:0];
    return (a.in0_addr == {1'b1, src}) || (!a.in1_src && in1 == {1'b1, src});
  endfunction

  function automatic logic ready_ok(input pu_alu_fields_t a);
    return !(uses_src(a, LD_OBUF) && !obuf_ld_ready) && !(uses_src(a, LD0_DDR) && !ddr_ld0_ready)
        && !(uses_src(a, LD1_DDR) && !ddr_ld1_ready) && !(a.out_addr[3] && !ddr_st_write_ready);
  endfunction

  task automatic wait_ack(input logic level);
    int n;
    n = 0;
    @(negedge clk);
    while (inst_ack !== level) begin
      n++;
      if (n > TIMEOUT) report_failure($sformatf("inst_ack never went to %b", level));
      @(negedge clk);
    end
  endtask

  task automatic send_inst(input pu_inst_u w);
    @(posedge clk);
    inst_req  <= 1'b1;
    inst_data <= w;
    wait_ack(1'b1);
    ack_valids = {cfg_loop_iter_v, cfg_loop_stride_v, cfg_mem_req_v};
    @(posedge clk);
    inst_req <= 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic send_setup(input pu_inst_u w, input logic [2:0] exp_v);
    int i0;
    int s0;
    int m0;
    i0 = iter_pulses;
    s0 = stride_pulses;
    m0 = mem_pulses;
    send_inst(w);
    check_type("cfg valids at rising inst_ack", 4'(ack_valids), 4'(exp_v));
    check_count("cfg_loop_iter_v pulses", iter_pulses - i0, int'(exp_v[2]));
    check_count("cfg_loop_stride_v pulses", stride_pulses - s0, int'(exp_v[1]));
    check_count("cfg_mem_req_v pulses", mem_pulses - m0, int'(exp_v[0]));
  endtask

  task automatic start_block();
    @(posedge clk);
    pu_block_start <= 1'b1;
    @(posedge clk);
    pu_block_start <= 1'b0;
  endtask

  task automatic load_block(input int n, input logic [`PU_IMM_W-1:0] reps);
    pu_inst_u w;
    model.delete();
    for (int i = 0; i < n; i++) begin
      w.alu = rand_compute();
      model.push_back(w.alu);
      send_inst(w);
    end
    send_inst(ctrl_word(BLOCK_REPEAT, 7'h0, reps));
    check_flag("pu_compute_ready", pu_compute_ready, 1'b1);
  endtask

  // one iteration per clock, checks every output of the compute phase
  task automatic run_compute(input int passes, input bit toggle_ready);
    pu_alu_fields_t exp_w;
    pu_alu_fields_t act_w;
    logic           exp_valid;
    logic [1:0]     st_hist;
    int             total;
    int             idx;
    int             k;
    int             last_k;
    int             n;
    total   = passes * model.size();
    idx     = 0;
    last_k  = -10;
    n       = 0;
    st_hist = '0;
    exp_w   = model[0];
    @(negedge clk);
    while (!pu_compute_ready) begin
      n++;
      if (n > TIMEOUT) report_failure("pu_compute_ready never went high");
      @(negedge clk);
    end
    @(posedge clk);
    pu_compute_start <= 1'b1;
    @(posedge clk);  // start sampled here
    pu_compute_start <= 1'b0;
    k = 1;
    while (1) begin
      if (toggle_ready) begin
        obuf_ld_ready <= 1'($urandom);
        ddr_ld0_ready <= 1'($urandom);
      end
      @(negedge clk);
      if (idx < total) exp_w = model[idx % model.size()];
      exp_valid = (k >= 3) && (idx < total) && ready_ok(exp_w);
      check_flag("alu_fn_valid", alu_fn_valid, exp_valid);
      check_flag("obuf_ld_req", obuf_ld_req, exp_valid && uses_src(exp_w, LD_OBUF));
      check_flag("ddr_ld0_req", ddr_ld0_req, exp_valid && uses_src(exp_w, LD0_DDR));
      check_flag("ddr_ld1_req", ddr_ld1_req, exp_valid && uses_src(exp_w, LD1_DDR));
      check_flag("ddr_st_write_req", ddr_st_write_req, st_hist[1]);
      check_flag("done", done, k == last_k + 1);
      check_flag("inst_ack", inst_ack, 1'b0);
      st_hist = {st_hist[0], exp_valid && exp_w.out_addr[3]};
      if (exp_valid) begin
        act_w.opcode   = i_dut.issue_inst.alu.opcode;
        act_w.in1_src  = alu_in1_src;
        act_w.fn       = alu_fn;
        act_w.imm      = alu_imm;
        act_w.in0_addr = alu_in0_addr;
        act_w.out_addr = alu_out_addr;
        check_opcode("issue_inst.opcode", act_w.opcode, exp_w.opcode);
        check_alu("alu fields", act_w, exp_w);
        check_type("alu_in1_addr", alu_in1_addr, exp_w.imm[3:0]);
        idx++;
        if (idx == total) last_k = k;
      end
      if (k == last_k + 2) break;
      if (k > 20 + 40 * total) report_failure("replay did not finish in time");
      @(posedge clk);
      k++;
    end
    @(posedge clk);
    obuf_ld_ready <= 1'b1;
    ddr_ld0_ready <= 1'b1;
  endtask

  // ============================================================
  // tests
  // ============================================================
  task automatic test_setup_decode();
    logic [`PU_IMM_W-1:0] hi;
    logic [`PU_IMM_W-1:0] lo;
    pu_inst_u             w;
    hi = `PU_IMM_W'($urandom);
    lo = `PU_IMM_W'($urandom);
    start_block();
    w = ctrl_word(LOOP, 7'b1100_101, `PU_IMM_W'($urandom));
    send_setup(w, 3'b100);
    check_cfg_iter("cfg_loop_iter", cfg_loop_iter, w.ctrl.imm);
    check_type("cfg_loop_iter_type", 4'(cfg_loop_iter_type), 4'd5);
    send_setup(ctrl_word(GENADDR_HI, 7'h0, hi), 3'b000);  // no pulse, high half only
    send_setup(ctrl_word(GENADDR_LO, 7'b101_0110, lo), 3'b010);
    check_cfg_stride("cfg_loop_stride", cfg_loop_stride, {hi, lo});
    check_type("cfg_loop_stride_type", cfg_loop_stride_type, 4'h6);
    send_setup(ctrl_word(LDMEM, 7'b001_0011, 16'h0), 3'b001);
    check_type("cfg_mem_req_type", 4'(cfg_mem_req_type), 4'd2);
    check_type("upsample_num", 4'(upsample_num), 4'd3);
    send_setup(ctrl_word(GENADDR_LO, 7'h09, ~lo), 3'b010);
    check_cfg_stride("cfg_loop_stride", cfg_loop_stride, {16'h0, ~lo});
    check_type("cfg_loop_stride_type", cfg_loop_stride_type, 4'h9);
  endtask

  task automatic test_gated_intake();
    start_block();
    load_block(N_WORDS, 16'd1);
    // block is closed, this request has to wait
    @(posedge clk);
    inst_req  <= 1'b1;
    inst_data <= ctrl_word(LOOP, 7'h3, 16'h1234);
    run_compute(2, 1'b0);
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      check_flag("inst_ack", inst_ack, 1'b0);
    end
    start_block();
    wait_ack(1'b1);
    check_flag("cfg_loop_iter_v", cfg_loop_iter_v, 1'b1);
    check_cfg_iter("cfg_loop_iter", cfg_loop_iter, 16'h1234);
    @(posedge clk);
    inst_req <= 1'b0;
    wait_ack(1'b0);
  endtask

  initial begin
    void'($urandom(32'h62ee9ec8));
    reset              = 1'b1;
    pu_block_start     = 1'b0;
    pu_compute_start   = 1'b0;
    inst_req           = 1'b0;
    inst_data          = '0;
    obuf_ld_ready      = 1'b1;
    ddr_ld0_ready      = 1'b1;
    ddr_ld1_ready      = 1'b1;
    ddr_st_write_ready = 1'b1;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_type("outputs after reset", 4'({inst_ack, cfg_loop_iter_v, cfg_loop_stride_v}), 4'h0);
    check_type("outputs after reset", 4'({cfg_mem_req_v, alu_fn_valid, done}), 4'h0);
    check_type("requests after reset", {obuf_ld_req, ddr_ld0_req, ddr_ld1_req, ddr_st_write_req},
               4'h0);
    check_flag("pu_compute_ready", pu_compute_ready, 1'b0);

    test_setup_decode();
    load_block(N_WORDS, 16'd0);  // still in decode from the setup words
    run_compute(1, 1'b0);
    start_block();
    load_block(N_WORDS, 16'd2);
    run_compute(3, 1'b0);
    start_block();
    load_block(N_WORDS + 2, 16'd1);
    run_compute(2, 1'b1);
    test_gated_intake();

    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: sources.f
+incdir+rtl
rtl/pu_pkg.sv
rtl/pu_imem_if.sv
rtl/pu_inst_mem.sv
rtl/pu_inst_decode.sv
rtl/pu_replay_seq.sv
rtl/pu_stream_issue.sv
rtl/pu_ctrl_top.sv
tb/pu_ctrl_tb.sv

// File: Makefile
TOP := pu_ctrl_tb
BIN := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): sources.f $(wildcard rtl/*.sv rtl/*.svh tb/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sources.f

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
